//--- block_quant.f
design/quant_pkg.sv
design/quant_table.sv
design/coef_quantizer.sv
design/row_quantizer.sv
design/block_quantizer.sv
bench/tb_block_quantizer.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f block_quant.f \
	--top-module tb_block_quantizer -o sim_block_quant \
	&& ./obj_dir/sim_block_quant | tee /dev/stderr | grep -q "^TEST PASS$" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

//--- bench/tb_block_quantizer.sv
`timescale 1ns/1ps

module tb_block_quantizer;

	import quant_pkg::*;

	localparam int TIMEOUT_CYCLES = 500;

	logic      clk;
	logic      arst_n;
	coef_row_t in_row;
	logic      in_valid;
	logic      in_ready;
	row_beat_t out_beat;
	logic      out_valid;
	logic      out_ready;

	// Standard luminance table in row-major order.
	int q_table [64] = '{
		16, 11, 10, 16, 24, 40, 51, 61,
		12, 12, 14, 19, 26, 58, 60, 55,
		14, 13, 16, 24, 40, 57, 69, 56,
		14, 17, 22, 29, 51, 87, 80, 62,
		18, 22, 37, 56, 68, 109, 103, 77,
		24, 35, 55, 64, 81, 104, 113, 92,
		49, 64, 78, 87, 103, 121, 120, 101,
		72, 92, 95, 98, 112, 100, 103, 99
	};

	row_beat_t expected_q [$];
	int        tb_row;
	int        want [8];
	logic      toggle_ready;
	logic      held_valid;
	row_beat_t held_beat;
	int        stall_cycles;
	int        last_seen;

	block_quantizer i_block_quantizer (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_row    (in_row),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.out_beat  (out_beat),
		.out_valid (out_valid),
		.out_ready (out_ready)
	);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#4 clk = ~clk;
		end
	end

	task automatic stop_on_error();
		$display("TEST FAIL");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_value(input string name, input int got, input int expected);
		if (got !== expected)
		begin
			$display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, expected);
			stop_on_error();
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out waiting for %s.", what);
		stop_on_error();
	endtask

	// Truncates toward zero and gives the result the sign of the coefficient.
	function automatic int quantize(input int x, input int q);
		int mag;
		mag = (x < 0) ? -x : x;
		mag = mag / q;
		return (x < 0) ? -mag : mag;
	endfunction

	function automatic int divisor_of(input int r, input int c);
		return q_table[6'(r * 8 + c)];
	endfunction

	function automatic coef_row_t random_row();
		coef_row_t row;
		for (int c = 0; c < COEFS_PER_ROW; c++)
		begin
			row[c] = coef_t'($urandom);
		end
		return row;
	endfunction

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic compare_beat(input string prefix, input row_beat_t got,
		input row_beat_t exp_beat);
		for (int c = 0; c < COEFS_PER_ROW; c++)
		begin
			check_value($sformatf("%s.coefs[%0d]", prefix, c), int'(got.coefs[c]),
				int'(exp_beat.coefs[c]));
		end
		check_value($sformatf("%s.last", prefix), int'(got.last), int'(exp_beat.last));
	endtask

	// Offers a row until it is taken, then queues the model result.
	task automatic send_row(input coef_row_t row);
		row_beat_t exp_beat;
		int        waited;
		logic      took;
		in_row = row;
		in_valid = 1'b1;
		took = 1'b0;
		waited = 0;
		while (!took)
		begin
			@(negedge clk);
			took = in_ready;
			step();
			waited++;
			if (!took && waited >= TIMEOUT_CYCLES)
			begin
				report_timeout("in_ready");
			end
		end
		in_valid = 1'b0;
		for (int c = 0; c < COEFS_PER_ROW; c++)
		begin
			exp_beat.coefs[c] = coef_t'(quantize(int'(row[c]), divisor_of(tb_row, c)));
		end
		exp_beat.last = (tb_row == ROWS_PER_BLOCK - 1);
		expected_q.push_back(exp_beat);
		tb_row = (tb_row + 1) % ROWS_PER_BLOCK;
	endtask

	task automatic wait_out_valid(output int cycles);
		cycles = 0;
		while (!out_valid)
		begin
			step();
			cycles++;
			if (cycles >= TIMEOUT_CYCLES)
			begin
				report_timeout("out_valid");
			end
		end
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		while (expected_q.size() != 0)
		begin
			step();
			waited++;
			if (waited >= TIMEOUT_CYCLES)
			begin
				report_timeout("the expected output rows to drain");
			end
		end
	endtask

	task automatic check_want(input logic last);
		for (int c = 0; c < COEFS_PER_ROW; c++)
		begin
			check_value($sformatf("out_beat.coefs[%0d]", c), int'(out_beat.coefs[c]), want[c]);
		end
		check_value("out_beat.last", int'(out_beat.last), int'(last));
	endtask

	// Output monitor samples mid-cycle where the outputs are settled.
	always @(negedge clk)
	begin
		if (!arst_n)
		begin
			held_valid = 1'b0;
		end
		else
		begin
			if (held_valid)
			begin
				check_value("out_valid while stalled", int'(out_valid), 1);
				compare_beat("stalled out_beat", out_beat, held_beat);
			end
			if (out_valid && out_ready)
			begin
				if (expected_q.size() == 0)
				begin
					$display("An output row arrived with no input row outstanding.");
					stop_on_error();
				end
				else
				begin
					compare_beat("out_beat", out_beat, expected_q[0]);
					void'(expected_q.pop_front());
					if (out_beat.last)
					begin
						last_seen++;
					end
				end
			end
			if (out_valid && !out_ready)
			begin
				stall_cycles++;
			end
			held_valid = out_valid && !out_ready;
			held_beat = out_beat;
		end
	end

	// Random consumer stalls.
	always @(posedge clk)
	begin
		#1;
		if (toggle_ready)
		begin
			out_ready = (($urandom & 32'd1) != 0);
		end
	end

	task automatic test_reset();
		check_value("out_valid", int'(out_valid), 0);
		check_value("in_ready", int'(in_ready), 1);
	endtask

	task automatic test_positive_row0();
		int        mult [8] = '{3, 7, 0, 16, 10, 2, 30, 33};
		int        rem [8] = '{5, 10, 9, 0, 23, 1, 50, 20};
		coef_row_t row;
		int        lat;
		out_ready = 1'b1;
		for (int c = 0; c < COEFS_PER_ROW; c++)
		begin
			row[c] = coef_t'(mult[c] * divisor_of(tb_row, c) + rem[c]);
			want[c] = mult[c];
		end
		send_row(row);
		// The row was taken on the edge just passed.
		wait_out_valid(lat);
		// out_valid rose on the following edge, so the beat transfers on the second one.
		check_value("out_valid latency", lat + 1, 2);
		check_want(1'b0);
		drain();
	endtask

	task automatic test_negative();
		coef_row_t row;
		int        lat;
		out_ready = 1'b1;
		row[0] = coef_t'(-1);
		want[0] = 0;
		row[1] = coef_t'(-(divisor_of(tb_row, 1) + 1));
		want[1] = -1;
		row[2] = coef_t'(-2048);
		want[2] = -(2048 / divisor_of(tb_row, 2));
		row[3] = coef_t'(-(6 * divisor_of(tb_row, 3) - 1));
		want[3] = -5;
		row[4] = coef_t'(-2048);
		want[4] = -(2048 / divisor_of(tb_row, 4));
		row[5] = coef_t'(-(divisor_of(tb_row, 5) - 1));
		want[5] = 0;
		row[6] = coef_t'(-2048);
		want[6] = -(2048 / divisor_of(tb_row, 6));
		row[7] = coef_t'(-(3 * divisor_of(tb_row, 7)));
		want[7] = -3;
		send_row(row);
		wait_out_valid(lat);
		check_value("out_valid latency", lat + 1, 2);
		check_want(1'b0);
		drain();
	endtask

	task automatic test_two_blocks();
		int lasts_before;
		out_ready = 1'b1;
		// Finish the open block so the stream starts on row 0.
		while (tb_row != 0)
		begin
			send_row(random_row());
		end
		drain();
		lasts_before = last_seen;
		for (int r = 0; r < 2 * ROWS_PER_BLOCK; r++)
		begin
			send_row(random_row());
		end
		drain();
		check_value("out_beat.last count", last_seen - lasts_before, 2);
	endtask

	task automatic test_backpressure();
		int gaps;
		stall_cycles = 0;
		toggle_ready = 1'b1;
		for (int n = 0; n < 48; n++)
		begin
			send_row(random_row());
			gaps = int'($urandom_range(0, 2));
			repeat (gaps) step();
		end
		toggle_ready = 1'b0;
		out_ready = 1'b1;
		drain();
		if (stall_cycles == 0)
		begin
			$display("The output was never stalled during the back-pressure test.");
			stop_on_error();
		end
	endtask

	initial
	begin
		void'($urandom(32'hf1e4));
		arst_n = 1'b0;
		in_row = '0;
		in_valid = 1'b0;
		out_ready = 1'b0;
		toggle_ready = 1'b0;
		tb_row = 0;
		held_valid = 1'b0;
		stall_cycles = 0;
		last_seen = 0;
		repeat (2) @(posedge clk);
		#1;
		arst_n = 1'b1;

		test_reset();
		test_positive_row0();
		test_negative();
		test_two_blocks();
		test_backpressure();

		if (expected_q.size() == 0)
		begin
			$display("TEST PASS");
			$finish;
		end
		else
		begin
			$display("Input rows were still outstanding at the end of the run.");
			stop_on_error();
		end
	end

endmodule

//--- design/block_quantizer.sv
`timescale 1ns/1ps

module block_quantizer (
	input  logic                 clk,
	input  logic                 arst_n,
	input  quant_pkg::coef_row_t in_row,
	input  logic                 in_valid,
	output logic                 in_ready,
	output quant_pkg::row_beat_t out_beat,
	output logic                 out_valid,
	input  logic                 out_ready
);

	import quant_pkg::*;

	row_idx_t row_cnt;
	logic     accept;

	// A row is taken on this edge.
	assign accept = in_valid && in_ready;

	// Row position within the current block.
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			row_cnt <= '0;
		end
		else if (accept)
		begin
			if (row_cnt == LAST_ROW)
			begin
				row_cnt <= '0;
			end
			else
			begin
				row_cnt <= row_cnt + 1'b1;
			end
		end
	end

	// Quantizing pipeline, it owns the handshake.
	row_quantizer i_row_quantizer (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_row    (in_row),
		.row_idx   (row_cnt),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.out_beat  (out_beat),
		.out_valid (out_valid),
		.out_ready (out_ready)
	);

endmodule

//--- design/row_quantizer.sv
`timescale 1ns/1ps

module row_quantizer (
	input  logic                 clk,
	input  logic                 arst_n,
	input  quant_pkg::coef_row_t in_row,
	input  quant_pkg::row_idx_t  row_idx,
	input  logic                 in_valid,
	output logic                 in_ready,
	output quant_pkg::row_beat_t out_beat,
	output logic                 out_valid,
	input  logic                 out_ready
);

	import quant_pkg::*;

	logic         advance;
	logic         s1_valid;
	row_beat_t    s1_beat;
	divisor_row_t divisors;
	coef_row_t    quotients;
	logic         s2_valid;
	row_beat_t    s2_beat;

	// Both stages move together when the output slot is free or being drained.
	assign advance = !s2_valid || out_ready;
	assign in_ready = advance;

	// Divisors are read alongside stage 1, so they line up with s1_beat.
	quant_table i_quant_table (
		.clk      (clk),
		.rd_en    (advance),
		.row_idx  (row_idx),
		.divisors (divisors)
	);

	// Stage 1 valid.
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			s1_valid <= 1'b0;
		end
		else if (advance)
		begin
			s1_valid <= in_valid;
		end
	end

	// Stage 1 payload.
	always_ff @(posedge clk)
	begin
		if (advance)
		begin
			s1_beat.coefs <= in_row;
			s1_beat.last <= (row_idx == LAST_ROW);
		end
	end

	// One divider lane per coefficient.
	for (genvar i = 0; i < COEFS_PER_ROW; i++)
	begin : g_lane
		coef_quantizer i_coef_quantizer (
			.coef     (s1_beat.coefs[i]),
			.divisor  (divisors[i]),
			.quotient (quotients[i])
		);
	end

	// Stage 2 valid.
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			s2_valid <= 1'b0;
		end
		else if (advance)
		begin
			s2_valid <= s1_valid;
		end
	end

	// Stage 2 payload, held while the consumer stalls.
	always_ff @(posedge clk)
	begin
		if (advance)
		begin
			s2_beat.coefs <= quotients;
			s2_beat.last <= s1_beat.last;
		end
	end

	assign out_beat = s2_beat;
	assign out_valid = s2_valid;

endmodule

//--- design/coef_quantizer.sv
`timescale 1ns/1ps

module coef_quantizer (
	input  quant_pkg::coef_t    coef,
	input  quant_pkg::divisor_t divisor,
	output quant_pkg::coef_t    quotient
);

	import quant_pkg::*;

	logic                neg;
	logic [COEF_W-1:0]   mag;
	logic [COEF_W-1:0]   mag_q;

	// Sign of the input decides the sign of the result.
	assign neg = coef[COEF_W-1];

	// Unsigned magnitude, -2048 maps to 12'h800.
	always_comb
	begin
		if (neg)
		begin
			mag = COEF_W'(-coef);
		end
		else
		begin
			mag = COEF_W'(coef);
		end
	end

	// Unsigned divide floors the magnitude, so the result truncates toward zero.
	assign mag_q = mag / COEF_W'(divisor);

	// A zero quotient keeps a plain zero.
	always_comb
	begin
		if (neg && (mag_q != '0))
		begin
			quotient = coef_t'(-mag_q);
		end
		else
		begin
			quotient = coef_t'(mag_q);
		end
	end

endmodule

//--- design/quant_table.sv
`timescale 1ns/1ps

module quant_table (
	input  logic                   clk,
	input  logic                   rd_en,
	input  quant_pkg::row_idx_t    row_idx,
	output quant_pkg::divisor_row_t divisors
);

	import quant_pkg::*;

	divisor_row_t rom_row;

	// Standard JPEG luminance table, row r and lane c.
	always_comb
	begin
		rom_row = '0;
		case (row_idx)
			3'd0:
			begin
				rom_row[0] = 8'd16;
				rom_row[1] = 8'd11;
				rom_row[2] = 8'd10;
				rom_row[3] = 8'd16;
				rom_row[4] = 8'd24;
				rom_row[5] = 8'd40;
				rom_row[6] = 8'd51;
				rom_row[7] = 8'd61;
			end
			3'd1:
			begin
				rom_row[0] = 8'd12;
				rom_row[1] = 8'd12;
				rom_row[2] = 8'd14;
				rom_row[3] = 8'd19;
				rom_row[4] = 8'd26;
				rom_row[5] = 8'd58;
				rom_row[6] = 8'd60;
				rom_row[7] = 8'd55;
			end
			3'd2:
			begin
				rom_row[0] = 8'd14;
				rom_row[1] = 8'd13;
				rom_row[2] = 8'd16;
				rom_row[3] = 8'd24;
				rom_row[4] = 8'd40;
				rom_row[5] = 8'd57;
				rom_row[6] = 8'd69;
				rom_row[7] = 8'd56;
			end
			3'd3:
			begin
				rom_row[0] = 8'd14;
				rom_row[1] = 8'd17;
				rom_row[2] = 8'd22;
				rom_row[3] = 8'd29;
				rom_row[4] = 8'd51;
				rom_row[5] = 8'd87;
				rom_row[6] = 8'd80;
				rom_row[7] = 8'd62;
			end
			3'd4:
			begin
				rom_row[0] = 8'd18;
				rom_row[1] = 8'd22;
				rom_row[2] = 8'd37;
				rom_row[3] = 8'd56;
				rom_row[4] = 8'd68;
				rom_row[5] = 8'd109;
				rom_row[6] = 8'd103;
				rom_row[7] = 8'd77;
			end
			3'd5:
			begin
				rom_row[0] = 8'd24;
				rom_row[1] = 8'd35;
				rom_row[2] = 8'd55;
				rom_row[3] = 8'd64;
				rom_row[4] = 8'd81;
				rom_row[5] = 8'd104;
				rom_row[6] = 8'd113;
				rom_row[7] = 8'd92;
			end
			3'd6:
			begin
				rom_row[0] = 8'd49;
				rom_row[1] = 8'd64;
				rom_row[2] = 8'd78;
				rom_row[3] = 8'd87;
				rom_row[4] = 8'd103;
				rom_row[5] = 8'd121;
				rom_row[6] = 8'd120;
				rom_row[7] = 8'd101;
			end
			default:
			begin
				rom_row[0] = 8'd72;
				rom_row[1] = 8'd92;
				rom_row[2] = 8'd95;
				rom_row[3] = 8'd98;
				rom_row[4] = 8'd112;
				rom_row[5] = 8'd100;
				rom_row[6] = 8'd103;
				rom_row[7] = 8'd99;
			end
		endcase
	end

	// Output register holds while the pipeline is stalled.
	always_ff @(posedge clk)
	begin
		if (rd_en)
		begin
			divisors <= rom_row;
		end
	end

endmodule

//--- design/quant_pkg.sv
package quant_pkg;

	// Coefficient and divisor widths.
	localparam int COEF_W = 12;
	localparam int DIVISOR_W = 8;

	// Block geometry, one row per stream transfer.
	localparam int COEFS_PER_ROW = 8;
	localparam int ROWS_PER_BLOCK = 8;
	localparam int ROW_IDX_W = 3;

	// One signed DCT coefficient.
	typedef logic signed [COEF_W-1:0] coef_t;

	// One entry of the quantization table.
	typedef logic [DIVISOR_W-1:0] divisor_t;

	// Row number within an 8x8 block.
	typedef logic [ROW_IDX_W-1:0] row_idx_t;

	// Index of the final row of a block.
	localparam row_idx_t LAST_ROW = row_idx_t'(ROWS_PER_BLOCK - 1);

	// A row of coefficients, lane 0 in the low bits.
	typedef coef_t [COEFS_PER_ROW-1:0] coef_row_t;

	// The divisors for one table row, lane 0 in the low bits.
	typedef divisor_t [COEFS_PER_ROW-1:0] divisor_row_t;

	// A row with its end-of-block marker.
	typedef struct packed {
		coef_row_t coefs;
		logic last;
	} row_beat_t;

endpackage
